// File: tb.f
+incdir+rtl
rtl/residual_pkg.sv
rtl/residual_apb_regs.sv
rtl/coded_word_ram.sv
rtl/bitstream_fetcher.sv
rtl/rice_stream_reader.sv
rtl/rice_decoder.sv
rtl/residual_decoder_top.sv
sim/residual_tb.sv

// File: sim/residual_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "residual_consts.svh"

module residualTb;

    logic                      iClock;
    logic                      rstN;
    residual_pkg::apbReqS      apbReq;
    residual_pkg::apbRspS      apbRsp;
    residual_pkg::residualOutS residual;

    int          resQ[$];        // Residuals fed to the encoder
    int          kList[$];       // Rice parameter per partition
    bit          bitQ[$];        // Encoded stream, first bit first
    logic [15:0] expQ[$];
    logic [15:0] expVal;
    int          outIdx = 0;
    int          mismatchCount = 0;
    int          otherCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 50;

    residual_decoder_top uut (
        .iClock   (iClock),
        .rstN     (rstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .residual (residual)
    );

    initial begin
        iClock = 1'b0;
        forever #20 iClock = ~iClock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB transfers, setup and access on falling edges
    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, output logic err);
        @(negedge iClock);
        apbReq = '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};
        @(negedge iClock);
        apbReq.enable = 1'b1;
        @(posedge iClock);
        err = apbRsp.slverr;
        assert (apbRsp.ready) else begin
            $display("APB ready was low in the write access phase at address %h", addr);
            otherCount++;
        end
        @(negedge iClock);
        apbReq.sel    = 1'b0;
        apbReq.enable = 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] data, output logic err);
        @(negedge iClock);
        apbReq = '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: 32'h0};
        @(negedge iClock);
        apbReq.enable = 1'b1;
        @(posedge iClock);
        data = apbRsp.rdata;   // Pre-edge value of the access phase
        err  = apbRsp.slverr;
        assert (apbRsp.ready) else begin
            $display("APB ready was low in the read access phase at address %h", addr);
            otherCount++;
        end
        @(negedge iClock);
        apbReq.sel    = 1'b0;
        apbReq.enable = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus generation and Rice encoding
    task automatic genResiduals(input int bs, input int pred, input int po);
        int n;
        int span;
        resQ.delete();
        for (int p = 0; p < (1 << po); p++) begin
            n    = (bs >> po) - ((p == 0) ? pred : 0);
            span = 1 << (kList[p] + 2);   // Keeps the quotient at four or less
            repeat (n) resQ.push_back(int'($urandom % span) - span / 2);
        end
    endtask

    task automatic encodeStream(input int bs, input int pred, input int po);
        int idx;
        int n;
        int u;
        idx = 0;
        bitQ.delete();
        for (int p = 0; p < (1 << po); p++) begin
            n = (bs >> po) - ((p == 0) ? pred : 0);
            for (int b = 3; b >= 0; b--)
                bitQ.push_back(((kList[p] >> b) & 1) != 0);
            for (int s = 0; s < n; s++) begin
                u = (resQ[idx] >= 0) ? 2 * resQ[idx] : -2 * resQ[idx] - 1;
                repeat (u >> kList[p]) bitQ.push_back(1'b0);
                bitQ.push_back(1'b1);
                for (int b = kList[p] - 1; b >= 0; b--)
                    bitQ.push_back(((u >> b) & 1) != 0);
                idx++;
            end
        end
    endtask

    // Reference model, parses the encoded bits by the FLAC partition rules
    function automatic int refDecode(input int bs, input int pred, input int po);
        int pos;
        int n;
        int k;
        int u;
        int count;
        pos   = 0;
        count = 0;
        for (int p = 0; p < (1 << po); p++) begin
            n = (bs >> po) - ((p == 0) ? pred : 0);
            k = 0;
            for (int b = 0; b < 4; b++) begin
                k = (k << 1) | bitQ[pos];
                pos++;
            end
            for (int s = 0; s < n; s++) begin
                u = 0;
                while (bitQ[pos] == 1'b0) begin
                    u++;
                    pos++;
                end
                pos++;
                for (int b = 0; b < k; b++) begin
                    u = (u << 1) | bitQ[pos];
                    pos++;
                end
                expQ.push_back(16'((u % 2 == 0) ? u / 2 : -(u + 1) / 2));
                count++;
            end
        end
        return count;
    endfunction

    task automatic waitDone();
        logic [31:0] rd;
        logic        err;
        rd = '0;
        while (!rd[1])
            apbRead(`RES_REG_STATUS, rd, err);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One decode run with the current resQ and kList
    task automatic runCase(input int bs, input int pred, input int po,
                           input int sAddr, input int sBit, input bit probe);
        logic [15:0]               img [0:`RES_RAM_DEPTH-1];
        residual_pkg::residualCfgS cfgS;
        logic [31:0]               rd;
        logic                      err;
        int                        wa;
        int                        bp;
        int                        nWords;
        encodeStream(bs, pred, po);
        cycleLimit += 2 * bitQ.size() + 50;
        void'(refDecode(bs, pred, po));
        for (int a = 0; a < `RES_RAM_DEPTH; a++)
            img[a] = 16'((a << 8) | (a ^ 'hFF));   // Filler around the stream
        wa = sAddr;
        bp = sBit;
        foreach (bitQ[i]) begin
            img[wa][bp] = bitQ[i];
            if (bp == 0) begin
                bp = 15;
                wa = (wa + 1) % `RES_RAM_DEPTH;
            end else begin
                bp--;
            end
        end
        nWords = (15 - sBit + bitQ.size() + 15) / 16;
        for (int i = 0; i < nWords; i++) begin
            wa = (sAddr + i) % `RES_RAM_DEPTH;
            apbWrite(`RES_RAM_BASE + 12'(wa << 2), {16'h0, img[wa]}, err);
        end
        cfgS = '{blockSize: 16'(bs), predictorOrder: 4'(pred), partitionOrder: 4'(po),
                 startBit: 5'(sBit), spare: 3'b0};
        apbWrite(`RES_REG_CFG, cfgS, err);
        apbWrite(`RES_REG_START, 32'(sAddr), err);
        apbWrite(`RES_REG_CTRL, 32'h1, err);
        if (probe) begin
            apbRead(`RES_REG_STATUS, rd, err);
            assert (rd[1:0] == 2'b01) else begin
                $display("MISMATCH STATUS: expected %h got %h", 2'b01, rd[1:0]);
                mismatchCount++;
            end
            apbWrite(`RES_REG_CTRL, 32'h1, err);   // Must not restart the run
        end
        waitDone();
        apbRead(`RES_REG_STATUS, rd, err);
        assert (rd[1:0] == 2'b10) else begin
            $display("MISMATCH STATUS: expected %h got %h", 2'b10, rd[1:0]);
            mismatchCount++;
        end
        apbRead(`RES_REG_COUNT, rd, err);
        assert (rd == 32'(bs - pred)) else begin
            $display("MISMATCH COUNT: expected %h got %h", 32'(bs - pred), rd);
            mismatchCount++;
        end
        assert (expQ.size() == 0) else begin
            $display("Run ended with %0d expected residuals never output", expQ.size());
            otherCount++;
        end
        expQ.delete();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output compare, sampled mid-cycle
    always @(negedge iClock) begin
        if (rstN && residual.valid) begin
            assert (expQ.size() > 0) else begin
                $display("Output %0d arrived with no expected residual left", outIdx);
                otherCount++;
            end
            if (expQ.size() > 0) begin
                expVal = expQ.pop_front();
                assert (residual.value == expVal) else begin
                    $display("MISMATCH residual.value: expected %h got %h at output %0d",
                             expVal, residual.value, outIdx);
                    mismatchCount++;
                end
                assert (residual.last == (expQ.size() == 0)) else begin
                    $display("Last flag is %0d at output %0d but %0d residuals remain",
                             residual.last, outIdx, expQ.size());
                    otherCount++;
                end
            end
            outIdx++;
        end
    end

    always @(negedge iClock) begin
        if (rstN)
            cycleCount = cycleCount + 1;
    end

    initial begin
        wait (rstN === 1'b1);
        while (cycleCount <= cycleLimit)
            @(posedge iClock);
        $display("Run stopped after %0d cycles, limit was %0d", cycleCount, cycleLimit);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int          po;
        int          partSize;
        int          pred;
        logic [31:0] rd;
        logic        err;
        void'($urandom(95448));
        apbReq = '0;
        rstN   = 1'b0;
        repeat (5) @(negedge iClock);
        rstN = 1'b1;

        resQ  = '{0, 1, -1, 2, -2, 3, -3, 7, -8, 5, -5, 20, -17, 6, -6, 0};
        kList = '{4};
        runCase(16, 0, 0, 0, 15, 1'b0);

        kList = '{2, 5, 0, 7};   // Partition 0 is three samples short
        genResiduals(32, 3, 2);
        runCase(32, 3, 2, 5, 15, 1'b0);

        kList = '{3, 6};
        genResiduals(24, 2, 1);
        runCase(24, 2, 1, 0, 15, 1'b0);
        runCase(24, 2, 1, 37, 6, 1'b0);   // Same stream placed mid-word

        resQ  = '{60, -61, 100, -100, 0, 1, -1, 45, -70, 99, -99, 2};
        kList = '{0};
        runCase(12, 0, 0, 90, 3, 1'b0);
        resQ  = '{32767, -32768, 16383, -16384, 1, -1, 0, -12345};
        kList = '{14};
        runCase(8, 0, 0, 250, 11, 1'b0);

        apbWrite(`RES_REG_CFG, 32'h1234_5A7D, err);
        apbRead(`RES_REG_CFG, rd, err);
        assert (rd == 32'h1234_5A7D && !err) else begin
            $display("MISMATCH CFG: expected %h got %h", 32'h1234_5A7D, rd);
            mismatchCount++;
        end
        apbRead(12'h020, rd, err);
        assert (err) else begin
            $display("Read of unmapped address 0x020 did not return slverr");
            otherCount++;
        end
        apbWrite(12'h014, 32'hFFFF_FFFF, err);
        assert (err) else begin
            $display("Write to unmapped address 0x014 did not return slverr");
            otherCount++;
        end
        kList = '{5, 9};
        genResiduals(64, 4, 1);
        runCase(64, 4, 1, 200, 9, 1'b1);

        for (int t = 0; t < 20; t++) begin
            po       = $urandom % 4;
            partSize = 4 + $urandom % 13;
            pred     = $urandom % partSize;
            kList.delete();
            repeat (1 << po) kList.push_back($urandom % 15);
            genResiduals(partSize << po, pred, po);
            runCase(partSize << po, pred, po, $urandom % 256, $urandom % 16, 1'b0);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/residual_decoder_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "residual_consts.svh"

module residual_decoder_top (
    input  wire logic                 iClock,
    input  wire logic                 rstN,
    input  wire residual_pkg::apbReqS apbReq,
    output residual_pkg::apbRspS      apbRsp,
    output residual_pkg::residualOutS residual
);

    residual_pkg::ramWriteS    ramWrite;
    residual_pkg::residualCfgS cfg;
    residual_pkg::riceSymbolS  symbol;
    logic [`RES_RAM_AW-1:0]    startAddr;
    logic [`RES_RAM_AW-1:0]    readAddr;
    logic [`RES_DATA_W-1:0]    readData;
    logic [`RES_DATA_W-1:0]    residualCount;
    logic                      start;
    logic                      streamBit;
    logic                      bitValid;
    logic                      streamDone;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side
    residual_apb_regs regs (
        .iClock        (iClock),
        .rstN          (rstN),
        .apbReq        (apbReq),
        .apbRsp        (apbRsp),
        .ramWrite      (ramWrite),
        .cfg           (cfg),
        .startAddr     (startAddr),
        .start         (start),
        .lastSeen      (residual.valid & residual.last),
        .residualCount (residualCount)
    );

    coded_word_ram ram (
        .iClock   (iClock),
        .ramWrite (ramWrite),
        .readAddr (readAddr),
        .readData (readData)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode pipeline
    bitstream_fetcher fetcher (
        .iClock    (iClock),
        .rstN      (rstN),
        .start     (start),
        .startAddr (startAddr),
        .startBit  (cfg.startBit),
        .readAddr  (readAddr),
        .readData  (readData),
        .stop      (streamDone),
        .streamBit (streamBit),
        .bitValid  (bitValid)
    );

    rice_stream_reader reader (
        .iClock     (iClock),
        .rstN       (rstN),
        .start      (start),
        .cfg        (cfg),
        .streamBit  (streamBit),
        .bitValid   (bitValid),
        .symbol     (symbol),
        .streamDone (streamDone)
    );

    rice_decoder decoder (
        .iClock        (iClock),
        .rstN          (rstN),
        .start         (start),
        .symbol        (symbol),
        .streamDone    (streamDone),
        .residual      (residual),
        .residualCount (residualCount)
    );

endmodule

`default_nettype wire

// File: rtl/rice_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "residual_consts.svh"

module rice_decoder (
    input  wire logic                     iClock,
    input  wire logic                     rstN,
    input  wire logic                     start,
    input  wire residual_pkg::riceSymbolS symbol,
    input  wire logic                     streamDone,
    output residual_pkg::residualOutS     residual,
    output logic [`RES_DATA_W-1:0]        residualCount
);

    logic [`RES_DATA_W-1:0] folded;
    logic [`RES_DATA_W-1:0] half;

    assign folded = (symbol.quotient << symbol.riceParam) | {1'b0, symbol.lsbs};
    assign half   = folded >> 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Zigzag unfold, odd folded values are the negatives
    always_ff @(posedge iClock) begin
        residual.value <= folded[0] ? $signed(~half) : $signed(half);
    end

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            residual.valid <= 1'b0;
            residual.last  <= 1'b0;
            residualCount  <= '0;
        end else begin
            residual.valid <= symbol.valid;
            residual.last  <= symbol.valid & streamDone;   // Final symbol meets streamDone
            if (start)
                residualCount <= '0;
            else if (symbol.valid)
                residualCount <= residualCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rice_stream_reader.sv
`timescale 1ns/10ps
`default_nettype none

`include "residual_consts.svh"

module rice_stream_reader (
    input  wire logic                      iClock,
    input  wire logic                      rstN,
    input  wire logic                      start,
    input  wire residual_pkg::residualCfgS cfg,
    input  wire logic                      streamBit,
    input  wire logic                      bitValid,
    output residual_pkg::riceSymbolS       symbol,
    output logic                           streamDone
);

    typedef enum logic [2:0] {
        IDLE,
        PARAM,
        UNARY,
        LOWBITS,
        DONE
    } readerStateE;

    readerStateE state;

    logic [`RES_RICE_PARAM_W-1:0] riceK;
    logic [`RES_RICE_PARAM_W-1:0] paramNext;
    logic [3:0]                   bitLeft;
    logic [15:0]                  partIdx;
    logic [15:0]                  sampLeft;
    logic [15:0]                  partSize;
    logic [15:0]                  partCount;
    logic [15:0]                  lastPartIdx;
    logic [`RES_DATA_W-1:0]       quotQ;
    logic [`RES_DATA_W-2:0]       lsbsQ;
    logic                         lastPart;
    logic                         emitNow;

    assign partSize    = cfg.blockSize >> cfg.partitionOrder;
    // Partition 0 loses the warm-up samples of the predictor
    assign partCount   = (partIdx == 16'd0) ? partSize - {12'd0, cfg.predictorOrder} : partSize;
    assign lastPartIdx = (16'd1 << cfg.partitionOrder) - 16'd1;
    assign lastPart    = partIdx == lastPartIdx;
    assign paramNext   = {riceK[`RES_RICE_PARAM_W-2:0], streamBit};
    assign streamDone  = state == DONE;

    assign emitNow = bitValid &&
                     ((state == UNARY && streamBit && riceK == '0) ||
                      (state == LOWBITS && bitLeft == 4'd0));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Parser FSM
    always_ff @(posedge iClock) begin
        if (!rstN) begin
            state <= IDLE;
        end else if (start) begin
            state   <= PARAM;
            bitLeft <= 4'd3;
            partIdx <= 16'd0;
        end else begin
            case (state)
                PARAM: if (bitValid) begin
                    riceK <= paramNext;   // Shifted in MSB first
                    if (bitLeft == 4'd0) begin
                        sampLeft <= partCount;
                        quotQ    <= '0;
                        state    <= UNARY;
                    end else begin
                        bitLeft <= bitLeft - 4'd1;
                    end
                end
                UNARY: if (bitValid) begin
                    if (!streamBit) begin
                        quotQ <= quotQ + 1'b1;
                    end else if (riceK != '0) begin
                        bitLeft <= riceK - 4'd1;
                        lsbsQ   <= '0;
                        state   <= LOWBITS;
                    end
                end
                LOWBITS: if (bitValid) begin
                    lsbsQ   <= {lsbsQ[`RES_DATA_W-3:0], streamBit};
                    bitLeft <= bitLeft - 4'd1;
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase

            // End of a sample overrides the per-state moves above
            if (emitNow) begin
                sampLeft <= sampLeft - 16'd1;
                if (sampLeft == 16'd1) begin
                    if (lastPart) begin
                        state <= DONE;
                    end else begin
                        partIdx <= partIdx + 16'd1;
                        bitLeft <= 4'd3;
                        state   <= PARAM;
                    end
                end else begin
                    quotQ <= '0;
                    state <= UNARY;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Symbol out, one cycle after its last bit
    always_ff @(posedge iClock) begin
        if (!rstN)
            symbol.valid <= 1'b0;
        else
            symbol.valid <= emitNow & ~start;
        symbol.quotient  <= quotQ;
        symbol.riceParam <= riceK;
        symbol.lsbs      <= (state == LOWBITS) ? {lsbsQ[`RES_DATA_W-3:0], streamBit} : '0;
    end

    // A symbol never trails the end of the stream
    symbolWhileActive: assert property (@(posedge iClock) disable iff (!rstN)
        symbol.valid |-> state != IDLE);

endmodule

`default_nettype wire

// File: rtl/bitstream_fetcher.sv
`timescale 1ns/10ps
`default_nettype none

`include "residual_consts.svh"

module bitstream_fetcher (
    input  wire logic                   iClock,
    input  wire logic                   rstN,
    input  wire logic                   start,
    input  wire logic [`RES_RAM_AW-1:0] startAddr,
    input  wire logic [4:0]             startBit,
    output logic [`RES_RAM_AW-1:0]      readAddr,
    input  wire logic [`RES_DATA_W-1:0] readData,
    input  wire logic                   stop,
    output logic                        streamBit,
    output logic                        bitValid
);

    logic [`RES_DATA_W-1:0] shiftBuf;
    logic [`RES_DATA_W-1:0] nextWord;
    logic [`RES_DATA_W-1:0] availWord;
    logic [`RES_RAM_AW-1:0] addrReg;
    logic [4:0]             bitCnt;     // Bits left in shiftBuf
    logic [3:0]             alignQ;
    logic                   nextValid;
    logic                   rdPending;
    logic                   firstLoad;
    logic                   running;
    logic                   avail;
    logic                   takeWord;
    logic                   issue;

    assign readAddr  = start ? startAddr : addrReg;
    assign streamBit = shiftBuf[`RES_DATA_W-1];
    assign avail     = nextValid | rdPending;
    assign availWord = nextValid ? nextWord : readData;   // Bypass straight from the RAM
    assign takeWord  = firstLoad | (bitValid & (bitCnt == 5'd1));
    // Keep one word in hand or on its way at all times
    assign issue     = running & ~stop & ~(avail & ~takeWord);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    always_ff @(posedge iClock) begin
        if (!rstN) begin
            running   <= 1'b0;
            bitValid  <= 1'b0;
            firstLoad <= 1'b0;
            rdPending <= 1'b0;
            nextValid <= 1'b0;
        end else if (start) begin
            running   <= 1'b1;
            bitValid  <= 1'b0;
            firstLoad <= 1'b1;
            rdPending <= 1'b1;
            nextValid <= 1'b0;
        end else if (stop) begin
            running   <= 1'b0;
            bitValid  <= 1'b0;
            firstLoad <= 1'b0;
            rdPending <= 1'b0;
            nextValid <= 1'b0;
        end else begin
            firstLoad <= 1'b0;
            if (firstLoad)
                bitValid <= 1'b1;
            rdPending <= issue;
            nextValid <= avail & ~takeWord;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shift buffer and prefetch
    always_ff @(posedge iClock) begin
        if (start) begin
            addrReg <= startAddr + 1'b1;
            alignQ  <= startBit[3:0];
        end else if (issue) begin
            addrReg <= addrReg + 1'b1;
        end
        if (rdPending && !takeWord)
            nextWord <= readData;
        if (takeWord) begin
            if (firstLoad) begin
                shiftBuf <= availWord << (4'd15 - alignQ);   // Bit startBit lands on top
                bitCnt   <= {1'b0, alignQ} + 5'd1;
            end else begin
                shiftBuf <= availWord;
                bitCnt   <= 5'd16;
            end
        end else if (bitValid) begin
            shiftBuf <= shiftBuf << 1;
            bitCnt   <= bitCnt - 5'd1;
        end
    end

    // The start bit has to fall inside the first word
    startAligned: assert property (@(posedge iClock) disable iff (!rstN)
        start |-> (startBit <= 5'd15));

endmodule

`default_nettype wire

// File: rtl/coded_word_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "residual_consts.svh"

module coded_word_ram (
    input  wire logic                   iClock,
    input  wire residual_pkg::ramWriteS ramWrite,
    input  wire logic [`RES_RAM_AW-1:0] readAddr,
    output logic [`RES_DATA_W-1:0]      readData
);

    logic [`RES_DATA_W-1:0] mem [0:`RES_RAM_DEPTH-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host writes through the APB window
    always_ff @(posedge iClock) begin
        if (ramWrite.en)
            mem[ramWrite.addr] <= ramWrite.data;
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge iClock) begin
        readData <= mem[readAddr];
    end

endmodule

`default_nettype wire

// File: rtl/residual_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "residual_consts.svh"

module residual_apb_regs (
    input  wire logic                    iClock,
    input  wire logic                    rstN,
    input  wire residual_pkg::apbReqS    apbReq,
    output residual_pkg::apbRspS         apbRsp,
    output residual_pkg::ramWriteS       ramWrite,
    output residual_pkg::residualCfgS    cfg,
    output logic [`RES_RAM_AW-1:0]       startAddr,
    output logic                         start,
    input  wire logic                    lastSeen,
    input  wire logic [`RES_DATA_W-1:0]  residualCount
);

    residual_pkg::residualCfgU cfgWord;
    logic busy;
    logic done;
    logic access;
    logic wrAccess;
    logic hitCfg, hitStart, hitCtrl, hitStatus, hitCount, hitRam;
    logic mapped;

    assign access   = apbReq.sel & apbReq.enable;
    assign wrAccess = access & apbReq.write & mapped;

    assign hitCfg    = apbReq.addr == `RES_REG_CFG;
    assign hitStart  = apbReq.addr == `RES_REG_START;
    assign hitCtrl   = apbReq.addr == `RES_REG_CTRL;
    assign hitStatus = apbReq.addr == `RES_REG_STATUS;
    assign hitCount  = apbReq.addr == `RES_REG_COUNT;
    assign hitRam    = (apbReq.addr & `RES_RAM_MASK) == `RES_RAM_BASE;
    assign mapped    = hitCfg | hitStart | hitCtrl | hitStatus | hitCount | hitRam;

    assign cfg = cfgWord.fields;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Zero wait state response
    always_comb begin
        apbRsp.ready  = 1'b1;
        apbRsp.slverr = access & ~mapped;
        apbRsp.rdata  = '0;
        if (hitCfg)
            apbRsp.rdata = cfgWord.raw;
        else if (hitStart)
            apbRsp.rdata = {{(32 - `RES_RAM_AW){1'b0}}, startAddr};
        else if (hitStatus)
            apbRsp.rdata = {30'b0, done, busy};
        else if (hitCount)
            apbRsp.rdata = {{(32 - `RES_DATA_W){1'b0}}, residualCount};
    end

    assign ramWrite.en   = wrAccess & hitRam;
    assign ramWrite.addr = apbReq.addr[9:2];   // Word index inside the window
    assign ramWrite.data = apbReq.wdata[`RES_DATA_W-1:0];

    always_ff @(posedge iClock) begin
        if (!rstN) begin
            cfgWord.raw <= '0;
            startAddr   <= '0;
            start       <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            if (wrAccess && hitCfg)
                cfgWord.raw <= apbReq.wdata;
            if (wrAccess && hitStart)
                startAddr <= apbReq.wdata[`RES_RAM_AW-1:0];
            start <= wrAccess & hitCtrl & apbReq.wdata[0] & ~busy & ~start;   // Dropped while busy
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (lastSeen) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // A run is only launched from idle, and busy follows on the next cycle
    startFromIdle: assert property (@(posedge iClock) disable iff (!rstN)
        start |-> !busy ##1 busy);

endmodule

`default_nettype wire

// File: rtl/residual_pkg.sv
`default_nettype none

`include "residual_consts.svh"

package residual_pkg;

    typedef struct packed {
        logic                   sel;
        logic                   enable;
        logic                   write;
        logic [`RES_APB_AW-1:0] addr;
        logic [31:0]            wdata;
    } apbReqS;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
        logic        slverr;
    } apbRspS;

    // Field layout of the CFG register, blockSize in the top half
    typedef struct packed {
        logic [15:0] blockSize;
        logic [3:0]  predictorOrder;
        logic [3:0]  partitionOrder;
        logic [4:0]  startBit;
        logic [2:0]  spare;
    } residualCfgS;

    typedef union packed {
        logic [31:0] raw;
        residualCfgS fields;
    } residualCfgU;

    typedef struct packed {
        logic                         valid;
        logic [`RES_DATA_W-1:0]       quotient;
        logic [`RES_DATA_W-2:0]       lsbs;
        logic [`RES_RICE_PARAM_W-1:0] riceParam;
    } riceSymbolS;

    typedef struct packed {
        logic                          valid;
        logic signed [`RES_DATA_W-1:0] value;
        logic                          last;
    } residualOutS;

    typedef struct packed {
        logic                   en;
        logic [`RES_RAM_AW-1:0] addr;
        logic [`RES_DATA_W-1:0] data;
    } ramWriteS;

endpackage

`default_nettype wire

// File: rtl/residual_consts.svh
`ifndef RESIDUAL_CONSTS_SVH
`define RESIDUAL_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath and memory sizes
`define RES_DATA_W        16
`define RES_RAM_DEPTH     256
`define RES_RAM_AW        8
`define RES_RICE_PARAM_W  4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB address map
`define RES_APB_AW        12
`define RES_REG_CFG       12'h000
`define RES_REG_START     12'h004
`define RES_REG_CTRL      12'h008
`define RES_REG_STATUS    12'h00C
`define RES_REG_COUNT     12'h010
`define RES_RAM_BASE      12'h400
`define RES_RAM_MASK      12'hC00   // Window spans 0x400 to 0x7FF

`endif
